// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - logic/cu_pkg.sv
  - logic/decode_if.sv
  - logic/instr_decoder.sv
  - logic/control_fsm.sv
  - logic/datapath_ctrl_gen.sv
  - logic/control_unit.sv
  - target: test
    files:
      - bench/control_unit_properties.sv
      - bench/control_unit_tb.sv

// ==== bench/control_unit_properties.sv ====
`timescale 1ns/1ps

module control_unit_properties import cu_pkg::*; (
    input logic       clock,
    input logic       reset,
    input logic       load_ir,
    input logic       mem_write,
    input logic       reg_write,
    input logic [3:0] state_code
);

    // Instruction register loads only while fetching
    load_ir_only_in_fetch: assert property (@(posedge clock) disable iff (reset)
        load_ir |-> (state_code == ST_FETCH))
        else $error("load_ir high outside the fetch state");

    // One write target per cycle
    no_double_write: assert property (@(posedge clock) disable iff (reset)
        !(mem_write && reg_write))
        else $error("mem_write and reg_write high in the same cycle");

    no_write_in_branch: assert property (@(posedge clock) disable iff (reset)
        (state_code == ST_BRANCH) |-> !reg_write)
        else $error("reg_write high in the branch state");

    legal_state_code: assert property (@(posedge clock) disable iff (reset)
        state_code inside {[4'd1:4'd9]})  // Codes 1 to 9 only
        else $error("state_code holds an illegal code");

endmodule

bind control_unit control_unit_properties u_properties (
    .clock      (clock),
    .reset      (reset),
    .load_ir    (load_ir),
    .mem_write  (mem_write),
    .reg_write  (reg_write),
    .state_code (state_code)
);

// ==== bench/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb import cu_pkg::*; ();

    typedef struct packed {
        logic [XLEN-1:0] word;
        logic            eq;
        logic            lt;
        logic            rnd;     // Flags drawn at random
        logic [2:0]      cycles;  // load_ir to load_ir
        logic [1:0]      rw;
        logic [1:0]      mw;
        logic [1:0]      pw;
        alu_op_t         alu;     // Expected in DECODE
        shift_op_t       sh;      // Expected in DECODE
    } row_t;

    logic            clock;
    logic            reset;
    logic [XLEN-1:0] instr;
    logic            equal;
    logic            less;
    logic            pc_write;
    logic            load_ir;
    logic            reg_a_write;
    logic            reg_b_write;
    logic            clear_a;
    logic            mem_data_load;
    logic            mem_write;
    logic            reg_write;
    alu_op_t         alu_op;
    a_sel_t          a_sel;
    b_sel_t          b_sel;
    shift_op_t       shift_op;
    wb_sel_t         wb_sel;
    logic [3:0]      state_code;

    row_t rows [0:39];
    int   n_rows;
    int   value_errors;
    int   timeout_errors;
    int   seed_value;
    logic timed_out;

    control_unit uut (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;  // 8 ns period

    function automatic logic [XLEN-1:0] fields(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};  // rs2 2, rs1 1, rd 3
    endfunction

    function automatic logic [XLEN-1:0] imm_word(input logic [11:0] imm, input logic [2:0] f3,
                                                 input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd2, opc};
    endfunction

    function automatic logic [XLEN-1:0] upper_word(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'd4, opc};
    endfunction

    task automatic add_row(input logic [XLEN-1:0] word, input logic eq, input logic lt,
                           input logic rnd, input int cycles, input int rw, input int mw,
                           input int pw, input alu_op_t alu, input shift_op_t sh);
        rows[n_rows] = {word, eq, lt, rnd, 3'(cycles), 2'(rw), 2'(mw), 2'(pw), alu, sh};
        n_rows++;
    endtask

    task automatic build_table();
        add_row(fields(F7_BASE, F3_ADD, OPC_R), 0, 0, 0, 3, 1, 0, 1, ALU_ADD, SH_NONE); // add
        add_row(fields(F7_SUB, F3_ADD, OPC_R), 0, 0, 0, 3, 1, 0, 1, ALU_SUB, SH_NONE); // sub
        add_row(fields(F7_BASE, F3_AND, OPC_R), 0, 0, 0, 3, 1, 0, 1, ALU_AND, SH_NONE); // and
        add_row(fields(F7_BASE, F3_SLT, OPC_R), 0, 0, 1, 4, 1, 0, 1, ALU_CMP, SH_NONE); // slt
        add_row(imm_word(12'd5, F3_ADD, OPC_I), 0, 0, 0, 3, 1, 0, 1, ALU_ADD, SH_NONE); // addi
        add_row(imm_word(12'd9, F3_SLT, OPC_I), 0, 0, 1, 4, 1, 0, 1, ALU_CMP, SH_NONE); // slti
        add_row(imm_word(12'h003, F3_SLL, OPC_I), 0, 0, 0, 3, 1, 0, 1, ALU_PASS_A, SH_SLL); // slli
        add_row(imm_word(12'h003, F3_SRL, OPC_I), 0, 0, 0, 3, 1, 0, 1, ALU_PASS_A, SH_SRL); // srli
        add_row(imm_word(12'h403, F3_SRL, OPC_I), 0, 0, 0, 3, 1, 0, 1, ALU_PASS_A, SH_SRA); // srai
        add_row(upper_word(20'h12345, OPC_LUI), 0, 0, 0, 3, 1, 0, 1, ALU_ADD, SH_NONE); // lui
        add_row(imm_word(12'd8, F3_DBL_LD, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_BYTE, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_HALF, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_WORD, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_BYTE_U, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_HALF_U, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd8, F3_WORD_U, OPC_LOAD), 0, 0, 0, 4, 1, 0, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd4, F3_DBL_ST, OPC_STORE), 0, 0, 0, 3, 0, 1, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd4, F3_WORD, OPC_STORE), 0, 0, 0, 3, 0, 1, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd4, F3_HALF, OPC_STORE), 0, 0, 0, 3, 0, 1, 1, ALU_ADD, SH_NONE);
        add_row(imm_word(12'd4, F3_BYTE, OPC_STORE), 0, 0, 0, 3, 0, 1, 1, ALU_ADD, SH_NONE);
        add_row(fields(7'd0, F3_BEQ, OPC_BRANCH), 1, 0, 0, 4, 0, 0, 3, ALU_CMP, SH_NONE); // taken
        add_row(fields(7'd0, F3_BEQ, OPC_BRANCH), 0, 1, 0, 3, 0, 0, 1, ALU_CMP, SH_NONE);
        add_row(fields(7'd0, F3_BNE, OPC_JALR_BR), 0, 1, 0, 4, 0, 0, 3, ALU_CMP, SH_NONE); // taken
        add_row(fields(7'd0, F3_BNE, OPC_JALR_BR), 1, 0, 0, 3, 0, 0, 1, ALU_CMP, SH_NONE);
        add_row(fields(7'd0, F3_BLT, OPC_JALR_BR), 0, 1, 0, 4, 0, 0, 3, ALU_CMP, SH_NONE); // taken
        add_row(fields(7'd0, F3_BLT, OPC_JALR_BR), 1, 0, 0, 3, 0, 0, 1, ALU_CMP, SH_NONE);
        add_row(fields(7'd0, F3_BGE, OPC_JALR_BR), 1, 0, 0, 4, 0, 0, 3, ALU_CMP, SH_NONE); // taken
        add_row(fields(7'd0, F3_BGE, OPC_JALR_BR), 0, 1, 0, 3, 0, 0, 1, ALU_CMP, SH_NONE);
        add_row(upper_word(20'h00100, OPC_JAL), 0, 0, 0, 5, 1, 0, 3, ALU_PASS_A, SH_NONE); // jal
        add_row(imm_word(12'd0, F3_JALR, OPC_JALR_BR), 0, 0, 0, 5, 1, 0, 3, ALU_PASS_A, SH_NONE);
        add_row(32'h0000_0013, 0, 0, 0, 2, 0, 0, 1, ALU_ADD, SH_NONE); // nop
        add_row(32'h0000_007f, 0, 0, 0, 2, 0, 0, 1, ALU_ADD, SH_NONE); // Unknown opcode
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Control word rules that follow from the state alone
    task automatic check_state_word(input int idx, input shift_op_t sh);
        case (state_code)
            4'd2: begin
                compare_value($sformatf("row %0d decode reg_a_write", idx), 1,
                              int'(reg_a_write));
                compare_value($sformatf("row %0d decode reg_b_write", idx), 1,
                              int'(reg_b_write));
                compare_value($sformatf("row %0d decode shift_op", idx), int'(sh),
                              int'(shift_op));
            end
            4'd4: compare_value($sformatf("row %0d wb_sel", idx), int'(WB_ALU), int'(wb_sel));
            4'd5: compare_value($sformatf("row %0d wb_sel", idx), int'(WB_MEM), int'(wb_sel));
            4'd9: begin
                compare_value($sformatf("row %0d pc fix alu_op", idx), int'(ALU_SUB),
                              int'(alu_op));
                compare_value($sformatf("row %0d pc fix a_sel", idx), int'(SEL_PC),
                              int'(a_sel));
                compare_value($sformatf("row %0d pc fix b_sel", idx), int'(SEL_FOUR),
                              int'(b_sel));
            end
            default: ;
        endcase
        compare_value($sformatf("row %0d mem_data_load", idx), int'(state_code == 4'd7),
                      int'(mem_data_load));  // Memory data captured only in MEM_READ
    endtask

    // Entered on a falling edge inside FETCH, leaves on the next FETCH
    task automatic run_row(input int idx);
        row_t    r;
        int      cycles;
        int      rw;
        int      mw;
        int      pw;
        alu_op_t dec_alu;
        logic    seen_fetch;
        r          = rows[idx];
        cycles     = 1;
        rw         = int'(reg_write);  // FETCH cycle counts too
        mw         = int'(mem_write);
        pw         = int'(pc_write);
        dec_alu    = ALU_PASS_A;
        seen_fetch = 1'b0;
        instr      = r.word;
        equal      = r.rnd ? (($urandom % 2) == 1) : r.eq;
        less       = r.rnd ? (($urandom % 2) == 1) : r.lt;
        while (!seen_fetch && cycles <= 20) begin
            @(negedge clock);
            if (load_ir) begin
                seen_fetch = 1'b1;
            end else begin
                cycles++;
                rw += int'(reg_write);
                mw += int'(mem_write);
                pw += int'(pc_write);
                check_state_word(idx, r.sh);
                if (state_code == 4'd2) dec_alu = alu_op;
                if (state_code == 4'd6)
                    compare_value($sformatf("row %0d compare alu_op", idx),
                                  less ? int'(ALU_INC_A) : int'(ALU_PASS_A), int'(alu_op));
            end
        end
        if (!seen_fetch) begin
            $display("Row %0d never returned to fetch within 20 cycles", idx);
            timeout_errors++;
            timed_out = 1'b1;
        end else begin
            compare_value($sformatf("row %0d cycles", idx), int'(r.cycles), cycles);
            compare_value($sformatf("row %0d reg_write pulses", idx), int'(r.rw), rw);
            compare_value($sformatf("row %0d mem_write pulses", idx), int'(r.mw), mw);
            compare_value($sformatf("row %0d pc_write pulses", idx), int'(r.pw), pw);
            compare_value($sformatf("row %0d decode alu_op", idx), int'(r.alu), int'(dec_alu));
        end
    endtask

    // break parks the FSM in DECODE
    task automatic check_halt();
        int n;
        instr = {12'd1, 5'd0, 3'd0, 5'd0, OPC_SYSTEM};
        for (n = 0; n < 20; n++) begin
            @(negedge clock);
            compare_value("halt state_code", 2, int'(state_code));
            compare_value("halt load_ir", 0, int'(load_ir));
        end
    endtask

    initial begin
        seed_value     = $urandom(32'h3b20);
        reset          = 1'b1;
        instr          = '0;
        equal          = 1'b0;
        less           = 1'b0;
        n_rows         = 0;
        value_errors   = 0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        build_table();
        repeat (8) @(posedge clock);
        @(negedge clock);
        compare_value("reset state_code", 1, int'(state_code));
        compare_value("reset load_ir", 1, int'(load_ir));
        compare_value("reset pc_write", 1, int'(pc_write));
        compare_value("reset reg_write", 0, int'(reg_write));
        compare_value("reset mem_write", 0, int'(mem_write));
        compare_value("reset clear_a", 0, int'(clear_a));
        compare_value("reset mem_data_load", 0, int'(mem_data_load));
        compare_value("reset reg_a_write", 0, int'(reg_a_write));
        compare_value("reset reg_b_write", 0, int'(reg_b_write));
        compare_value("reset a_sel", int'(SEL_PC), int'(a_sel));      // PC plus four
        compare_value("reset b_sel", int'(SEL_FOUR), int'(b_sel));
        reset = 1'b0;  // Still in FETCH until the next rising edge
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            run_row(i);
        end
        if (!timed_out) check_halt();
        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/cu_pkg.sv
logic/decode_if.sv
logic/instr_decoder.sv
logic/control_fsm.sv
logic/datapath_ctrl_gen.sv
logic/control_unit.sv
bench/control_unit_properties.sv
bench/control_unit_tb.sv

// ==== logic/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import cu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    decode_if.sequencer dec,
    input  logic        equal,         // rs1 equals rs2, from the datapath
    input  logic        less,          // rs1 below rs2, from the datapath
    output ctrl_state_t state,
    output logic        branch_taken
);

    ctrl_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ST_FETCH;  // Next fetch starts right after reset
        end else begin
            state <= next_state;
        end
    end

    // Flag decision, only meaningful in BRANCH and COMPARE
    always_comb begin
        branch_taken = 1'b0;
        if (state == ST_BRANCH) begin
            case (dec.op)
                OP_BEQ:          branch_taken = equal;
                OP_BNE:          branch_taken = !equal;
                OP_BLT:          branch_taken = less;
                OP_BGE:          branch_taken = !less;
                OP_JAL, OP_JALR: branch_taken = 1'b1;  // Jumps always redirect
                default:         branch_taken = 1'b0;
            endcase
        end else if (state == ST_COMPARE) begin
            branch_taken = less;  // slt result for the generator
        end
    end

    always_comb begin
        next_state = ST_FETCH;
        case (state)
            ST_FETCH: next_state = ST_DECODE;
            ST_DECODE: begin
                case (dec.op_class)
                    CLS_ALU:     next_state = ST_WRITE_ALU;
                    CLS_COMPARE: next_state = ST_COMPARE;
                    CLS_LOAD:    next_state = ST_MEM_READ;
                    CLS_STORE:   next_state = ST_MEM_WRITE;
                    CLS_BRANCH:  next_state = ST_BRANCH;
                    CLS_JUMP:    next_state = ST_WRITE_ALU;  // Link first, then jump
                    CLS_HALT:    next_state = ST_DECODE;     // Parked until reset
                    CLS_NONE:    next_state = ST_FETCH;
                    default:     next_state = ST_FETCH;
                endcase
            end
            ST_WRITE_ALU: begin
                if (dec.writes_link) begin
                    next_state = ST_BRANCH;
                end else begin
                    next_state = ST_FETCH;
                end
            end
            ST_COMPARE:   next_state = ST_WRITE_ALU;
            ST_MEM_READ:  next_state = ST_WRITE_MEM;
            ST_WRITE_MEM: next_state = ST_FETCH;
            ST_MEM_WRITE: next_state = ST_FETCH;
            ST_BRANCH: begin
                // Only a redirected PC needs the minus four fix
                if (branch_taken) begin
                    next_state = ST_PC_FIX;
                end else begin
                    next_state = ST_FETCH;
                end
            end
            ST_PC_FIX: next_state = ST_FETCH;
            default:   next_state = ST_FETCH;  // Recover from illegal codes
        endcase
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import cu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [XLEN-1:0] instr,          // Instruction register contents
    input  logic            equal,
    input  logic            less,
    output logic            pc_write,
    output logic            load_ir,
    output logic            reg_a_write,
    output logic            reg_b_write,
    output logic            clear_a,
    output logic            mem_data_load,
    output logic            mem_write,
    output logic            reg_write,
    output alu_op_t         alu_op,
    output a_sel_t          a_sel,
    output b_sel_t          b_sel,
    output shift_op_t       shift_op,
    output wb_sel_t         wb_sel,
    output logic [3:0]      state_code      // Current state for debug
);

    ctrl_state_t state;
    logic        branch_taken;

    decode_if dec_bus ();  // Decoded instruction, shared by FSM and generator

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec_bus.source)
    );

    control_fsm u_fsm (
        .clock        (clock),
        .reset        (reset),
        .dec          (dec_bus.sequencer),
        .equal        (equal),
        .less         (less),
        .state        (state),
        .branch_taken (branch_taken)
    );

    datapath_ctrl_gen u_ctrl_gen (
        .dec           (dec_bus.generator),
        .state         (state),
        .branch_taken  (branch_taken),
        .pc_write      (pc_write),
        .load_ir       (load_ir),
        .reg_a_write   (reg_a_write),
        .reg_b_write   (reg_b_write),
        .clear_a       (clear_a),
        .mem_data_load (mem_data_load),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .alu_op        (alu_op),
        .a_sel         (a_sel),
        .b_sel         (b_sel),
        .shift_op      (shift_op),
        .wb_sel        (wb_sel)
    );

    assign state_code = state;

endmodule

// ==== logic/cu_pkg.sv ====
package cu_pkg;

    localparam int XLEN     = 32;  // Instruction word width
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    // Major opcodes
    localparam logic [OPCODE_W-1:0] OPC_R       = 7'd51;
    localparam logic [OPCODE_W-1:0] OPC_I       = 7'd19;
    localparam logic [OPCODE_W-1:0] OPC_LOAD    = 7'd3;
    localparam logic [OPCODE_W-1:0] OPC_STORE   = 7'd35;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH  = 7'd99;   // beq only
    localparam logic [OPCODE_W-1:0] OPC_JALR_BR = 7'd103;  // bne, bge, blt and jalr share it
    localparam logic [OPCODE_W-1:0] OPC_LUI     = 7'd55;
    localparam logic [OPCODE_W-1:0] OPC_JAL     = 7'd111;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM  = 7'd115;  // break

    // Arithmetic funct3
    localparam logic [FUNCT3_W-1:0] F3_ADD = 3'd0;  // add, sub, addi
    localparam logic [FUNCT3_W-1:0] F3_SLL = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_SLT = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_SRL = 3'd5;  // srli and srai
    localparam logic [FUNCT3_W-1:0] F3_AND = 3'd7;

    // Memory access widths
    localparam logic [FUNCT3_W-1:0] F3_BYTE   = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_HALF   = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_WORD   = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_DBL_LD = 3'd3;
    localparam logic [FUNCT3_W-1:0] F3_BYTE_U = 3'd4;
    localparam logic [FUNCT3_W-1:0] F3_HALF_U = 3'd5;
    localparam logic [FUNCT3_W-1:0] F3_WORD_U = 3'd6;
    localparam logic [FUNCT3_W-1:0] F3_DBL_ST = 3'd7;  // sd is not on 3 here

    // Branch and jalr funct3
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'd4;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'd5;
    localparam logic [FUNCT3_W-1:0] F3_JALR = 3'd0;

    localparam logic [6:0] F7_BASE  = 7'd0;
    localparam logic [6:0] F7_SUB   = 7'd32;
    localparam logic [5:0] F6_LOGIC = 6'd0;   // Shift field above shamt
    localparam logic [5:0] F6_ARITH = 6'd16;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_SLT,
        OP_ADDI, OP_SLTI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LD, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU,
        OP_SD, OP_SW, OP_SH, OP_SB,
        OP_BEQ, OP_BNE, OP_BGE, OP_BLT,
        OP_JAL, OP_JALR, OP_LUI, OP_NOP, OP_HALT
    } instr_op_t;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_COMPARE, CLS_LOAD, CLS_STORE,
        CLS_BRANCH, CLS_JUMP, CLS_NONE, CLS_HALT
    } op_class_t;

    // Codes show up on state_code
    typedef enum logic [3:0] {
        ST_FETCH     = 4'd1,
        ST_DECODE    = 4'd2,
        ST_BRANCH    = 4'd3,
        ST_WRITE_ALU = 4'd4,
        ST_WRITE_MEM = 4'd5,
        ST_COMPARE   = 4'd6,
        ST_MEM_READ  = 4'd7,
        ST_MEM_WRITE = 4'd8,
        ST_PC_FIX    = 4'd9
    } ctrl_state_t;

    typedef enum logic [2:0] {
        ALU_PASS_A = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_INC_A  = 3'd4,
        ALU_CMP    = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {SEL_PC = 3'd0, SEL_REG_A = 3'd1} a_sel_t;
    typedef enum logic [2:0] {
        SEL_REG_B = 3'd0, SEL_FOUR = 3'd1, SEL_IMM = 3'd2, SEL_IMM_BRANCH = 3'd3
    } b_sel_t;
    typedef enum logic [1:0] {SH_SLL = 2'd0, SH_SRL = 2'd1, SH_SRA = 2'd2, SH_NONE = 2'd3} shift_op_t;
    typedef enum logic [2:0] {WB_ALU = 3'd0, WB_MEM = 3'd1} wb_sel_t;

endpackage

// ==== logic/datapath_ctrl_gen.sv ====
`timescale 1ns/1ps

module datapath_ctrl_gen import cu_pkg::*; (
    decode_if.generator dec,
    input  ctrl_state_t state,
    input  logic        branch_taken,
    output logic        pc_write,
    output logic        load_ir,
    output logic        reg_a_write,
    output logic        reg_b_write,
    output logic        clear_a,        // Zeroes register A
    output logic        mem_data_load,  // Memory data register capture
    output logic        mem_write,
    output logic        reg_write,
    output alu_op_t     alu_op,
    output a_sel_t      a_sel,
    output b_sel_t      b_sel,
    output shift_op_t   shift_op,
    output wb_sel_t     wb_sel
);

    alu_op_t   dec_alu;    // ALU code used in DECODE
    shift_op_t dec_shift;
    logic      is_jump;

    always_comb begin
        dec_alu   = ALU_ADD;  // Loads, stores, addi and lui add
        dec_shift = SH_NONE;
        case (dec.op)
            OP_SUB: dec_alu = ALU_SUB;
            OP_AND: dec_alu = ALU_AND;
            OP_SLT, OP_SLTI, OP_BEQ, OP_BNE, OP_BGE, OP_BLT: dec_alu = ALU_CMP;
            OP_SLLI: begin
                dec_alu   = ALU_PASS_A;  // Shifter acts on A
                dec_shift = SH_SLL;
            end
            OP_SRLI: begin
                dec_alu   = ALU_PASS_A;
                dec_shift = SH_SRL;
            end
            OP_SRAI: begin
                dec_alu   = ALU_PASS_A;
                dec_shift = SH_SRA;
            end
            OP_JAL, OP_JALR: dec_alu = ALU_PASS_A;  // Link value is PC
            default: dec_alu = ALU_ADD;
        endcase
    end

    assign is_jump = (dec.op == OP_JAL) || (dec.op == OP_JALR);

    always_comb begin
        pc_write      = 1'b0;
        load_ir       = 1'b0;
        reg_a_write   = 1'b0;
        reg_b_write   = 1'b0;
        clear_a       = 1'b0;
        mem_data_load = 1'b0;
        mem_write     = 1'b0;
        reg_write     = 1'b0;
        alu_op        = ALU_PASS_A;
        a_sel         = SEL_PC;
        b_sel         = SEL_REG_B;
        shift_op      = SH_NONE;
        wb_sel        = WB_ALU;
        case (state)
            ST_FETCH: begin
                load_ir  = 1'b1;
                pc_write = 1'b1;  // PC plus four
                alu_op   = ALU_ADD;
                b_sel    = SEL_FOUR;
            end
            ST_DECODE: begin
                reg_a_write = 1'b1;
                reg_b_write = 1'b1;
                alu_op      = dec_alu;
                shift_op    = dec_shift;
                a_sel       = is_jump ? SEL_PC : SEL_REG_A;
                b_sel       = dec.uses_imm ? SEL_IMM : SEL_REG_B;
                clear_a     = (dec.op == OP_LUI);  // lui is 0 plus imm
            end
            ST_COMPARE: begin
                clear_a = 1'b1;
                a_sel   = SEL_REG_A;
                alu_op  = branch_taken ? ALU_INC_A : ALU_PASS_A;  // 1 or 0 into rd
            end
            ST_WRITE_ALU: begin
                reg_write = 1'b1;
                wb_sel    = WB_ALU;
            end
            ST_MEM_READ: begin
                mem_data_load = 1'b1;
                alu_op        = ALU_ADD;  // Keep the address on the bus
                a_sel         = SEL_REG_A;
                b_sel         = SEL_IMM;
            end
            ST_MEM_WRITE: begin
                mem_write = 1'b1;
                alu_op    = ALU_ADD;
                a_sel     = SEL_REG_A;
                b_sel     = SEL_IMM;
            end
            ST_WRITE_MEM: begin
                reg_write = 1'b1;
                wb_sel    = WB_MEM;
            end
            ST_BRANCH: begin
                alu_op   = ALU_ADD;
                pc_write = branch_taken;
                if (dec.op == OP_JALR) begin
                    a_sel = SEL_REG_A;  // rs1 plus imm
                    b_sel = SEL_IMM;
                end else begin
                    a_sel = SEL_PC;
                    b_sel = SEL_IMM_BRANCH;
                end
            end
            ST_PC_FIX: begin
                pc_write = 1'b1;
                alu_op   = ALU_SUB;  // Undo the fetch increment
                a_sel    = SEL_PC;
                b_sel    = SEL_FOUR;
            end
            default: wb_sel = WB_ALU;  // Illegal codes drive the idle word
        endcase
    end

endmodule

// ==== logic/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if import cu_pkg::*; ();

    instr_op_t op;           // One operation per instruction word
    op_class_t op_class;     // Picks the state sequence
    logic      uses_imm;     // B operand from the immediate
    logic      writes_link;  // jal and jalr write PC to rd

    modport source (
        output op, op_class, uses_imm, writes_link
    );

    modport sequencer (
        input op_class, op, writes_link
    );

    modport generator (
        input op, uses_imm
    );

endinterface

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import cu_pkg::*; (
    input  logic [XLEN-1:0] instr,  // Held by the instruction register
    decode_if.source        dec
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [6:0]          funct7;
    logic [5:0]          funct6;       // Shifts keep bit 25 in shamt
    instr_op_t           op;
    op_class_t           op_class;
    logic                uses_imm;
    logic                writes_link;

    assign opcode = instr[OPCODE_W-1:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];

    always_comb begin
        op = OP_NOP;  // Anything unmatched runs as nop
        case (opcode)
            OPC_R: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  op = OP_ADD;
                        F3_AND:  op = OP_AND;
                        F3_SLT:  op = OP_SLT;
                        default: op = OP_NOP;
                    endcase
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    op = OP_SUB;
                end
            end
            OPC_I: begin
                if (instr[XLEN-1:OPCODE_W] == '0) begin
                    op = OP_NOP;  // addi x0, x0, 0
                end else begin
                    case (funct3)
                        F3_ADD:  op = OP_ADDI;
                        F3_SLT:  op = OP_SLTI;
                        F3_SLL:  op = (funct6 == F6_LOGIC) ? OP_SLLI : OP_NOP;
                        F3_SRL: begin
                            if (funct6 == F6_LOGIC) begin
                                op = OP_SRLI;
                            end else if (funct6 == F6_ARITH) begin
                                op = OP_SRAI;
                            end
                        end
                        default: op = OP_NOP;
                    endcase
                end
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_DBL_LD: op = OP_LD;
                    F3_BYTE:   op = OP_LB;
                    F3_HALF:   op = OP_LH;
                    F3_WORD:   op = OP_LW;
                    F3_BYTE_U: op = OP_LBU;
                    F3_HALF_U: op = OP_LHU;
                    F3_WORD_U: op = OP_LWU;
                    default:   op = OP_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_DBL_ST: op = OP_SD;
                    F3_WORD:   op = OP_SW;
                    F3_HALF:   op = OP_SH;
                    F3_BYTE:   op = OP_SB;
                    default:   op = OP_NOP;
                endcase
            end
            OPC_BRANCH:  op = (funct3 == F3_BEQ) ? OP_BEQ : OP_NOP;
            OPC_JALR_BR: begin
                case (funct3)
                    F3_BNE:  op = OP_BNE;
                    F3_JALR: op = OP_JALR;
                    F3_BGE:  op = OP_BGE;
                    F3_BLT:  op = OP_BLT;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LUI:    op = OP_LUI;
            OPC_JAL:    op = OP_JAL;
            OPC_SYSTEM: op = OP_HALT;  // break
            default:    op = OP_NOP;
        endcase
    end

    always_comb begin
        uses_imm    = 1'b0;
        writes_link = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_SLLI, OP_SRLI, OP_SRAI: op_class = CLS_ALU;
            OP_ADDI, OP_LUI: begin
                op_class = CLS_ALU;
                uses_imm = 1'b1;
            end
            OP_SLT:  op_class = CLS_COMPARE;
            OP_SLTI: begin
                op_class = CLS_COMPARE;
                uses_imm = 1'b1;
            end
            OP_LD, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                op_class = CLS_LOAD;
                uses_imm = 1'b1;  // Address is rs1 plus offset
            end
            OP_SD, OP_SW, OP_SH, OP_SB: begin
                op_class = CLS_STORE;
                uses_imm = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BGE, OP_BLT: op_class = CLS_BRANCH;
            OP_JAL, OP_JALR: begin
                op_class    = CLS_JUMP;
                writes_link = 1'b1;
            end
            OP_HALT: op_class = CLS_HALT;
            default: op_class = CLS_NONE;
        endcase
    end

    assign dec.op          = op;
    assign dec.op_class    = op_class;
    assign dec.uses_imm    = uses_imm;
    assign dec.writes_link = writes_link;

endmodule
